//--- design/fcvt_d2l.sv
`timescale 1ns/1ns

module fcvt_d2l
    import fcvt_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_nrst,
    input  fcvt_cmd_t i_cmd,
    output fcvt_res_t o_res
);

    logic [CVT_LATENCY:0] vld;

    logic              in_signed;
    logic              in_w32;
    logic [63:0]       in_a;

    // Stage 1, unpack and classify
    logic [EXP_W-1:0]  s1_exp;
    logic [MANT_W:0]   s1_mant;         // Hidden bit on top
    logic              s1_sign;
    logic              s1_nan;
    logic              s1_inf;
    logic              s1_zero;
    logic              s1_signed;
    logic              s1_w32;

    // Stage 2, alignment
    logic signed [EXP_W+1:0] ue;
    logic [127:0]      wide;
    logic [63:0]       mag;
    logic              sticky;
    logic              big;
    logic [63:0]       s2_mag;
    logic              s2_sticky;
    logic              s2_big;
    logic              s2_sign;
    logic              s2_nan;
    logic              s2_inf;
    logic              s2_signed;
    logic              s2_w32;

    // Stage 3, sign and saturation
    logic [63:0]       lim_pos;
    logic [63:0]       lim_neg;
    logic [63:0]       raw;
    logic              nv;
    logic [63:0]       value_q;
    logic              nv_q;
    logic              nx_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            vld <= '0;
        end else begin
            vld <= {vld[CVT_LATENCY-1:0], i_cmd.start};
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_cmd.start) begin
            in_signed <= i_cmd.is_signed;
            in_w32    <= i_cmd.is_w32;
            in_a      <= i_cmd.operand;
        end
        if (vld[0]) begin
            s1_sign   <= in_a[63];
            s1_exp    <= in_a[62:52];
            s1_mant   <= {|in_a[62:52], in_a[51:0]};
            s1_nan    <= (&in_a[62:52]) & (|in_a[51:0]);
            s1_inf    <= (&in_a[62:52]) & ~(|in_a[51:0]);
            s1_zero   <= ~|in_a[62:0];
            s1_signed <= in_signed;
            s1_w32    <= in_w32;
        end
    end

    // Hidden bit lands on bit 64+ue, fraction in the low half
    always_comb begin
        ue   = $signed({2'b00, s1_exp}) - $signed((EXP_W+2)'(EXP_BIAS));
        wide = {s1_mant, 75'd0} >> (6'd63 - ue[5:0]);
        if (ue < 0) begin
            big    = 1'b0;
            mag    = 64'd0;
            sticky = ~s1_zero;          // Magnitude below one
        end else if (ue > 63) begin
            big    = 1'b1;
            mag    = 64'd0;
            sticky = 1'b0;
        end else begin
            big    = 1'b0;
            mag    = wide[127:64];
            sticky = |wide[63:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (vld[1]) begin
            s2_mag    <= mag;
            s2_sticky <= sticky;
            s2_big    <= big;
            s2_sign   <= s1_sign;
            s2_nan    <= s1_nan;
            s2_inf    <= s1_inf;
            s2_signed <= s1_signed;
            s2_w32    <= s1_w32;
        end
    end

    // Largest magnitude allowed on each side of zero
    always_comb begin
        case ({s2_w32, s2_signed})
            2'b00:   {lim_pos, lim_neg} = {64'hFFFF_FFFF_FFFF_FFFF, 64'd0};
            2'b01:   {lim_pos, lim_neg} = {64'h7FFF_FFFF_FFFF_FFFF, 64'h8000_0000_0000_0000};
            2'b10:   {lim_pos, lim_neg} = {64'h0000_0000_FFFF_FFFF, 64'd0};
            default: {lim_pos, lim_neg} = {64'h0000_0000_7FFF_FFFF, 64'h0000_0000_8000_0000};
        endcase
        nv = s2_nan | s2_inf | s2_big | (s2_sign ? (s2_mag > lim_neg) : (s2_mag > lim_pos));
        if (nv) begin
            raw = (s2_sign & ~s2_nan) ? (~lim_neg + 64'd1) : lim_pos;  // NaN goes positive
        end else begin
            raw = s2_sign ? (~s2_mag + 64'd1) : s2_mag;
        end
    end

    always_ff @(posedge i_clk) begin
        if (vld[2]) begin
            value_q <= s2_w32 ? {{32{raw[31]}}, raw[31:0]} : raw;   // W results sign-extended
            nv_q    <= nv;
            nx_q    <= s2_sticky & ~nv;
        end
    end

    assign o_res = '{done: vld[CVT_LATENCY], flags: '{nv: nv_q, nx: nx_q}, value: value_q};

endmodule

//--- design/fcvt_issue.sv
`timescale 1ns/1ns

module fcvt_issue
    import fcvt_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_valid,
    input  fcvt_op_e    i_op,
    input  logic [63:0] i_a,
    input  logic        i_retired,      // Result presented at the output
    output logic        o_ready,
    output fcvt_cmd_t   o_l2d_cmd,
    output fcvt_cmd_t   o_d2l_cmd
);

    logic busy;
    logic accept;
    logic to_d2l;
    logic op_signed;
    logic op_w32;

    // Ready returns in the same cycle the result is shown
    assign o_ready = ~busy | i_retired;
    assign accept  = i_valid & o_ready;

    // Opcode decode into direction, signedness and width
    always_comb begin
        case (i_op)
            OP_D_L:  {to_d2l, op_signed, op_w32} = 3'b010;
            OP_D_LU: {to_d2l, op_signed, op_w32} = 3'b000;
            OP_D_W:  {to_d2l, op_signed, op_w32} = 3'b011;
            OP_D_WU: {to_d2l, op_signed, op_w32} = 3'b001;
            OP_L_D:  {to_d2l, op_signed, op_w32} = 3'b110;
            OP_LU_D: {to_d2l, op_signed, op_w32} = 3'b100;
            OP_W_D:  {to_d2l, op_signed, op_w32} = 3'b111;
            OP_WU_D: {to_d2l, op_signed, op_w32} = 3'b101;
            default: {to_d2l, op_signed, op_w32} = 3'b000;
        endcase
    end

    // Both buses share the operand, only one gets the start pulse
    assign o_l2d_cmd = '{start: accept & ~to_d2l, is_signed: op_signed,
                         is_w32: op_w32, operand: i_a};
    assign o_d2l_cmd = '{start: accept & to_d2l, is_signed: op_signed,
                         is_w32: op_w32, operand: i_a};

    // One operation in flight at a time
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;           // A new command wins over the retiring one
        end else if (i_retired) begin
            busy <= 1'b0;
        end
    end

endmodule

//--- design/fcvt_l2d.sv
`timescale 1ns/1ns

module fcvt_l2d
    import fcvt_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_nrst,
    input  fcvt_cmd_t i_cmd,
    output fcvt_res_t o_res
);

    logic [CVT_LATENCY:0] vld;          // Bit 0 marks the input register

    // Input register
    logic              in_signed;
    logic              in_w32;
    logic [63:0]       in_a;

    // Stage 1, extension and magnitude
    logic [63:0]       ext_a;
    logic              neg_a;
    logic              s1_sign;
    logic [63:0]       s1_abs;

    // Stage 2, normalisation
    logic [5:0]        lz;
    logic [63:0]       norm;
    logic              s2_sign;
    logic              s2_zero;
    logic [5:0]        s2_shift;
    logic [63:0]       s2_mant;

    // Stage 3, rounding
    logic              rnd;
    logic              mant_ones;
    logic [EXP_W-1:0]  exp_r;
    logic [MANT_W-1:0] frac_r;
    logic [63:0]       s3_value;
    logic [63:0]       value_q;
    logic              nx_q;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            vld <= '0;
        end else begin
            vld <= {vld[CVT_LATENCY-1:0], i_cmd.start};
        end
    end

    // Operand sampled on the accepting edge
    always_ff @(posedge i_clk) begin
        if (i_cmd.start) begin
            in_signed <= i_cmd.is_signed;
            in_w32    <= i_cmd.is_w32;
            in_a      <= i_cmd.operand;
        end
    end

    always_comb begin
        if (!in_w32) begin
            ext_a = in_a;
        end else if (in_signed) begin
            ext_a = {{32{in_a[31]}}, in_a[31:0]};
        end else begin
            ext_a = {32'd0, in_a[31:0]};
        end
        neg_a = in_signed & ext_a[63];
    end

    always_ff @(posedge i_clk) begin
        if (vld[0]) begin
            s1_sign <= neg_a;
            s1_abs  <= neg_a ? (~ext_a + 64'd1) : ext_a;    // 2^63 stays 2^63
        end
    end

    // Highest set bit wins since the loop runs upward
    always_comb begin
        lz = 6'd0;
        for (int i = 0; i < 64; i++) begin
            if (s1_abs[i]) begin
                lz = 6'(63 - i);
            end
        end
        norm = s1_abs << lz;
    end

    always_ff @(posedge i_clk) begin
        if (vld[1]) begin
            s2_sign  <= s1_sign;
            s2_zero  <= ~|s1_abs;
            s2_shift <= lz;
            s2_mant  <= norm;
        end
    end

    // Nearest even on the 11 bits below the mantissa
    always_comb begin
        rnd       = s2_mant[10] & ((|s2_mant[9:0]) | s2_mant[11]);
        mant_ones = &s2_mant[62:11];
        exp_r     = EXP_W'(L2D_EXP_TOP) - EXP_W'(s2_shift) + EXP_W'(rnd & mant_ones);
        frac_r    = s2_mant[62:11] + MANT_W'(rnd);     // Wraps to zero on carry out
        if (s2_zero) begin
            s3_value = 64'd0;
        end else begin
            s3_value = {s2_sign, exp_r, frac_r};
        end
    end

    always_ff @(posedge i_clk) begin
        if (vld[2]) begin
            value_q <= s3_value;
            nx_q    <= |s2_mant[10:0];
        end
    end

    always_comb begin
        o_res.done     = vld[CVT_LATENCY];
        o_res.flags.nv = 1'b0;          // Every integer fits a double
        o_res.flags.nx = nx_q;
        o_res.value    = value_q;
    end

endmodule

//--- design/fcvt_pkg.sv
package fcvt_pkg;

    // Conversion opcodes
    // The first four go integer to double, the last four double to integer
    typedef enum logic [2:0] {
        OP_D_L  = 3'd0,     // Signed 64-bit to double
        OP_D_LU = 3'd1,     // Unsigned 64-bit to double
        OP_D_W  = 3'd2,     // Signed 32-bit to double
        OP_D_WU = 3'd3,     // Unsigned 32-bit to double
        OP_L_D  = 3'd4,     // Double to signed 64-bit
        OP_LU_D = 3'd5,     // Double to unsigned 64-bit
        OP_W_D  = 3'd6,     // Double to signed 32-bit
        OP_WU_D = 3'd7      // Double to unsigned 32-bit
    } fcvt_op_e;

    // Command into one converter
    typedef struct packed {
        logic        start;         // Single cycle, only on the selected converter
        logic        is_signed;
        logic        is_w32;
        logic [63:0] operand;
    } fcvt_cmd_t;

    // Exception flags
    typedef struct packed {
        logic nv;                   // Invalid
        logic nx;                   // Inexact
    } fcvt_flags_t;

    // Converter result
    typedef struct packed {
        logic        done;
        fcvt_flags_t flags;
        logic [63:0] value;
    } fcvt_res_t;

    // Double format
    localparam int EXP_BIAS = 1023;
    localparam int EXP_W    = 11;
    localparam int MANT_W   = 52;

    // Exponent for a leading one at bit 63, bias plus 63
    localparam int L2D_EXP_TOP = 1086;

    // Edges after acceptance until a converter raises done
    localparam int CVT_LATENCY = 3;

endpackage

//--- design/fcvt_retire.sv
`timescale 1ns/1ns

module fcvt_retire
    import fcvt_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  fcvt_res_t   i_l2d,
    input  fcvt_res_t   i_d2l,
    output logic        o_valid,
    output logic [63:0] o_res,
    output fcvt_flags_t o_flags
);

    fcvt_res_t pick;
    logic      done_any;

    // At most one converter finishes in a given cycle
    always_comb begin
        done_any = i_l2d.done | i_d2l.done;
        if (i_l2d.done) begin
            pick = i_l2d;
        end else begin
            pick = i_d2l;
        end
    end

    // Result and flags hold until the next completion
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_valid <= 1'b0;
            o_res   <= 64'd0;
            o_flags <= '0;
        end else begin
            o_valid <= done_any;        // Single cycle pulse
            if (done_any) begin
                o_res   <= pick.value;
                o_flags <= pick.flags;
            end
        end
    end

endmodule

//--- design/fcvt_top.sv
`timescale 1ns/1ns

module fcvt_top
    import fcvt_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_valid,
    input  fcvt_op_e    i_op,
    input  logic [63:0] i_a,
    output logic        o_ready,
    output logic        o_valid,
    output logic [63:0] o_res,
    output fcvt_flags_t o_flags
);

    fcvt_cmd_t l2d_cmd;
    fcvt_cmd_t d2l_cmd;
    fcvt_res_t l2d_res;
    fcvt_res_t d2l_res;

    fcvt_issue u_issue (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .i_valid   (i_valid),
        .i_op      (i_op),
        .i_a       (i_a),
        .i_retired (o_valid),           // Frees the unit for the next command
        .o_ready   (o_ready),
        .o_l2d_cmd (l2d_cmd),
        .o_d2l_cmd (d2l_cmd)
    );

    fcvt_l2d u_l2d (.i_clk(i_clk), .i_nrst(i_nrst), .i_cmd(l2d_cmd), .o_res(l2d_res));

    fcvt_d2l u_d2l (.i_clk(i_clk), .i_nrst(i_nrst), .i_cmd(d2l_cmd), .o_res(d2l_res));

    fcvt_retire u_retire (
        .i_clk   (i_clk),
        .i_nrst  (i_nrst),
        .i_l2d   (l2d_res),
        .i_d2l   (d2l_res),
        .o_valid (o_valid),
        .o_res   (o_res),
        .o_flags (o_flags)
    );

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module fcvt_tb -f vlog.f -o fcvt_sim

# Keep running past assertion failures so the closing line is printed
./obj_dir/fcvt_sim +verilator+error+limit+100000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0

//--- verification/fcvt_checker.sv
`timescale 1ns/1ns

module fcvt_checker
    import fcvt_pkg::*;
(
    input logic        i_clk,
    input logic        i_nrst,
    input logic        i_valid,
    input fcvt_op_e    i_op,
    input logic [63:0] i_a,
    input logic        o_ready,
    input logic        o_valid,
    input logic [63:0] o_res,
    input fcvt_flags_t o_flags
);

    int          err_cnt = 0;
    int          res_cnt;
    logic [4:0]  acc_sr;            // Bit n set when a command was accepted n+1 edges ago
    logic [65:0] exp_q;             // Expected {nv, nx, value}
    logic [65:0] last_q;

    // Nearest even double of the extended integer
    function automatic logic [65:0] int_to_double(input fcvt_op_e op, input logic [63:0] a);
        logic [63:0] x;
        logic [63:0] mag;
        real         r;
        int          hi;
        int          lo;
        x = (op == OP_D_W) ? {{32{a[31]}}, a[31:0]} : (op == OP_D_WU) ? {32'd0, a[31:0]} : a;
        if (op == OP_D_LU && x[63]) begin
            r   = 2.0 * real'(longint'({1'b0, x[63:1]} | {63'd0, x[0]}));   // Halve, keep sticky
            mag = x;
        end else begin
            r   = real'(longint'(x));
            mag = x[63] ? -x : x;
        end
        hi = -1;
        lo = -1;
        for (int i = 0; i < 64; i++) begin
            if (mag[i]) begin
                hi = i;
                if (lo < 0) begin
                    lo = i;
                end
            end
        end
        // Exact only when the set bits span at most 53 positions
        return {1'b0, (hi - lo) > 52, $realtobits(r)};
    endfunction

    // Truncation toward zero with saturation
    function automatic logic [65:0] double_to_int(input fcvt_op_e op, input logic [63:0] a);
        real         d;
        real         t;
        real         lo;
        real         hi;
        logic [63:0] max_v;
        logic [63:0] min_v;
        logic [63:0] v;
        d     = $bitstoreal(a);
        lo    = op[0] ? -1.0 : (op[1] ? -2147483649.0 : -9223372036854777856.0);
        hi    = op[1] ? (op[0] ? 4294967296.0 : 2147483648.0)
                      : (op[0] ? 18446744073709551616.0 : 9223372036854775808.0);
        max_v = op[0] ? 64'hFFFF_FFFF_FFFF_FFFF
                      : (op[1] ? 64'h0000_0000_7FFF_FFFF : 64'h7FFF_FFFF_FFFF_FFFF);
        min_v = op[0] ? 64'd0 : (op[1] ? 64'hFFFF_FFFF_8000_0000 : 64'h8000_0000_0000_0000);
        if ((&a[62:52]) && (|a[51:0])) begin
            return {2'b10, max_v};              // NaN
        end
        if (!(d > lo && d < hi)) begin
            return {2'b10, (d < 0.0) ? min_v : max_v};
        end
        t = (d < 0.0) ? $ceil(d) : $floor(d);
        if (t >= 9223372036854775808.0) begin
            v = 64'(longint'(t - 9223372036854775808.0)) | 64'h8000_0000_0000_0000;
        end else begin
            v = longint'(t);
        end
        if (op[1]) begin
            v = {{32{v[31]}}, v[31:0]};         // Word results sign-extended
        end
        return {1'b0, t != d, v};
    endfunction

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            acc_sr  <= '0;
            res_cnt <= 0;
            last_q  <= '0;
        end else begin
            acc_sr <= {acc_sr[3:0], i_valid & o_ready};
            last_q <= {o_flags, o_res};
            if (o_valid) begin
                res_cnt <= res_cnt + 1;
            end
        end
    end

    // Reference result computed at acceptance
    always_ff @(posedge i_clk) begin
        if (i_valid && o_ready) begin
            exp_q <= i_op[2] ? double_to_int(i_op, i_a) : int_to_double(i_op, i_a);
        end
    end

    a_reset: assert property (@(posedge i_clk) !i_nrst |-> (!o_valid && o_ready))
        else begin
            err_cnt++;
            $error("ERR %0t o_valid/o_ready expected 0/1 got %b/%b", $time, o_valid, o_ready);
        end

    a_latency: assert property (@(posedge i_clk) disable iff (!i_nrst) o_valid == acc_sr[4])
        else begin
            err_cnt++;
            $error("ERR %0t o_valid expected %b got %b", $time, acc_sr[4], o_valid);
        end

    a_busy: assert property (@(posedge i_clk) disable iff (!i_nrst) (|acc_sr[3:0]) |-> !o_ready)
        else begin
            err_cnt++;
            $error("ERR %0t o_ready expected 0 got %b", $time, o_ready);
        end

    // Ready again from the o_valid cycle on, and whenever idle
    a_ready: assert property (@(posedge i_clk) disable iff (!i_nrst)
                              (acc_sr[3:0] == 4'd0) |-> o_ready)
        else begin
            err_cnt++;
            $error("ERR %0t o_ready expected 1 got %b", $time, o_ready);
        end

    a_value: assert property (@(posedge i_clk) disable iff (!i_nrst)
                              o_valid |-> (o_res == exp_q[63:0]))
        else begin
            err_cnt++;
            $error("ERR %0t o_res expected %h got %h", $time, exp_q[63:0], o_res);
        end

    a_flags: assert property (@(posedge i_clk) disable iff (!i_nrst)
                              o_valid |-> (o_flags == exp_q[65:64]))
        else begin
            err_cnt++;
            $error("ERR %0t o_flags expected %b got %b", $time, exp_q[65:64], o_flags);
        end

    // Outputs only move on the edge that raises o_valid
    a_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
                             !o_valid |-> ({o_flags, o_res} == last_q))
        else begin
            err_cnt++;
            $error("ERR %0t o_flags/o_res expected %h got %h", $time, last_q, {o_flags, o_res});
        end

endmodule

bind fcvt_top fcvt_checker u_checker (.*);

//--- verification/fcvt_tb.sv
`timescale 1ns/1ns

module fcvt_tb
    import fcvt_pkg::*;
();

    localparam int N_CORNER = 16;
    localparam int N_RAND   = 400;
    localparam int TIMEOUT  = (N_CORNER * 8 + N_RAND) * 8 + 100;

    logic        clk = 1'b0;
    logic        nrst;
    logic        valid;
    fcvt_op_e    op;
    logic [63:0] a;
    logic        ready;
    logic        res_valid;
    logic [63:0] res;
    fcvt_flags_t flags;
    logic [31:0] lfsr = 32'h0c1913a4;
    int          sent = 0;
    int          errors = 0;
    int          cycles = 0;

    logic [63:0] corners [N_CORNER] = '{
        64'h0000_0000_0000_0000,
        64'h0000_0000_0000_0001,
        64'hFFFF_FFFF_FFFF_FFFF,    // -1
        64'h8000_0000_0000_0000,    // 2^63
        64'h0020_0000_0000_0001,    // 2^53+1
        64'hFFFF_FFFF_FFFF_FFFF,
        64'h0000_0000_7FFF_FFFF,
        64'h0000_0000_8000_0000,
        64'h3FE0_0000_0000_0000,    // +0.5
        64'hBFE0_0000_0000_0000,    // -0.5
        64'hBFF0_0000_0000_0000,    // -1.0
        64'h4629_3E59_39A0_8CEA,    // 1e30
        64'h7FF0_0000_0000_0000,
        64'hFFF0_0000_0000_0000,
        64'h7FF8_0000_0000_0000,    // Quiet NaN
        64'h43E0_0000_0000_0000     // 2^63 as a double
    };

    fcvt_top DUT (
        .i_clk   (clk),
        .i_nrst  (nrst),
        .i_valid (valid),
        .i_op    (op),
        .i_a     (a),
        .o_ready (ready),
        .o_valid (res_valid),
        .o_res   (res),
        .o_flags (flags)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit, newest bit at the bottom
    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic send_cmd(input fcvt_op_e c_op, input logic [63:0] c_a, input logic poke);
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        valid = 1'b1;
        op    = c_op;
        a     = c_a;
        sent++;
        @(negedge clk);             // Accepted on the edge just passed
        if (poke) begin
            a = ~c_a;               // Offered while busy
            repeat (2) @(negedge clk);
        end
        valid = 1'b0;
    endtask

    initial begin : watchdog
        while (cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: no idle DUT after %0d cycles", cycles);
        $display("Finished with errors");
        $finish;
    end

    initial begin : stimulus
        logic [63:0] r;
        logic [63:0] ra;
        logic [63:0] rs;
        fcvt_op_e    rop;
        nrst  = 1'b0;
        valid = 1'b0;
        op    = OP_D_L;
        a     = '0;
        repeat (8) @(negedge clk);
        nrst = 1'b1;
        for (int c = 0; c < N_CORNER; c++) begin
            for (int o = 0; o < 8; o++) begin
                send_cmd(fcvt_op_e'(3'(o)), corners[c], 1'b0);
            end
        end
        for (int k = 0; k < N_RAND; k++) begin
            rand_bits(3, r);
            rop = fcvt_op_e'(r[2:0]);
            rand_bits(64, ra);
            rand_bits(8, rs);
            if (rop[2] && rs[0]) begin
                ra[62:52] = 11'h3F0 + 11'(rs[7:1]);     // Exponent near the integer range
            end else if (!rop[2] && rs[0]) begin
                ra = ra >> rs[6:1];                     // Smaller magnitudes
            end
            send_cmd(rop, ra, (k % 5) == 4);
        end
        @(negedge clk);
        while (!ready) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        if (DUT.u_checker.res_cnt != sent) begin
            $display("Result count wrong: %0d commands sent, %0d results seen",
                     sent, DUT.u_checker.res_cnt);
            errors++;
        end
        errors += DUT.u_checker.err_cnt;
        $display("Commands %0d, results %0d, errors %0d", sent, DUT.u_checker.res_cnt, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- vlog.f
design/fcvt_pkg.sv
design/fcvt_issue.sv
design/fcvt_l2d.sv
design/fcvt_d2l.sv
design/fcvt_retire.sv
design/fcvt_top.sv
verification/fcvt_checker.sv
verification/fcvt_tb.sv
